/* rtl/cordic_num_pkg.sv */
// Numeric format of the CORDIC datapath: widths, Q2.30 data type and X start value
package cordic_num_pkg;

    // ========================================================================
    // Word format
    // ========================================================================
    parameter int DATA_W        = 32;   // Full word width
    parameter int FRAC_W        = 30;   // Fraction bits of Q2.30
    parameter int ITER_BITS_DEF = 4;    // Default counter width, 16 iterations

    // Signed Q2.30, two's complement, wraps on overflow
    typedef logic signed [DATA_W-1:0] data_t;

    // ========================================================================
    // Start values
    // ========================================================================
    // 1/K of the rotation gain, 0.607252935 in Q2.30
    // X starts here so no final scaling is needed
    parameter data_t CORDIC_GAIN_INV = 32'h26DD3B6A;

endpackage

/* rtl/cordic_ctrl_pkg.sv */
// Control encodings: FSM states, shared adder grant and quadrant number
package cordic_ctrl_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,       // Waiting for start
        LOAD,       // Capture inputs, set start values
        SHIFT,      // Snapshot and shifted operands
        UPDATE,     // One variable per cycle through the adder
        COMMIT,     // Next values into X/Y/Z
        OUTPUT,     // Register the corrected result
        DONE        // Hold ready until ack
    } fsm_state_t;

    // Grant of the shared add/subtract unit
    typedef enum logic [1:0] {
        VAR_X = 2'd0,
        VAR_Y = 2'd1,
        VAR_Z = 2'd2
    } var_sel_t;

    typedef logic [1:0] quadrant_t;     // Quadrant k of the reduced angle

endpackage

/* rtl/cordic_atan_rom.sv */
// Arctangent table atan(2^-i) in Q2.30, indexed by the iteration counter
module cordic_atan_rom #(
    parameter int ITER_BITS = cordic_num_pkg::ITER_BITS_DEF  // Iteration counter width
) (
    input  logic [ITER_BITS-1:0]  iter,     // Current iteration i
    output cordic_num_pkg::data_t atan      // atan(2^-i), rounded
);
    import cordic_num_pkg::*;

    always_comb
    begin
        case (int'(iter))
            0:       atan = data_t'(32'h3243F6A9);   // pi/4
            1:       atan = data_t'(32'h1DAC6705);
            2:       atan = data_t'(32'h0FADBAFD);
            3:       atan = data_t'(32'h07F56EA7);
            4:       atan = data_t'(32'h03FEAB77);
            5:       atan = data_t'(32'h01FFD55C);
            6:       atan = data_t'(32'h00FFFAAB);
            7:       atan = data_t'(32'h007FFF55);
            8:       atan = data_t'(32'h003FFFEB);
            9:       atan = data_t'(32'h001FFFFD);
            10:      atan = data_t'(32'h00100000);   // From here atan(x) rounds to x
            11:      atan = data_t'(32'h00080000);
            12:      atan = data_t'(32'h00040000);
            13:      atan = data_t'(32'h00020000);
            14:      atan = data_t'(32'h00010000);
            15:      atan = data_t'(32'h00008000);
            default:
            begin
                // Deep iterations, small-angle value 2^-i
                if (int'(iter) <= FRAC_W)
                    atan = data_t'(1) <<< (FRAC_W - int'(iter));
                else
                    atan = '0;
            end
        endcase
    end

endmodule

/* rtl/cordic_fsm.sv */
// CORDIC sequencer FSM with iteration counter, variable counter and ready flag
module cordic_fsm #(
    parameter int ITER_BITS = cordic_num_pkg::ITER_BITS_DEF  // Iteration counter width
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,      // Host request, seen in IDLE only
    input  logic                      ack,        // Host took the result
    output logic                      ready,      // Result valid, held until ack
    output logic                      load_en,    // Capture inputs and start values
    output logic                      shift_en,   // Snapshot and shift stage
    output logic                      wr_en,      // Write adder sum to next value
    output logic                      commit_en,  // Next values into X/Y/Z
    output logic                      out_en,     // Register the result
    output cordic_ctrl_pkg::var_sel_t var_sel,    // Adder grant, X then Y then Z
    output logic [ITER_BITS-1:0]      iter        // Current iteration
);
    import cordic_ctrl_pkg::*;

    fsm_state_t state;
    fsm_state_t state_nxt;
    logic       last_iter;

    assign last_iter = (iter == {ITER_BITS{1'b1}});

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (start)
                    state_nxt = LOAD;
            end
            LOAD:    state_nxt = SHIFT;
            SHIFT:   state_nxt = UPDATE;
            UPDATE:
            begin
                if (var_sel == VAR_Z)                // Z is the last of the three
                    state_nxt = COMMIT;
            end
            COMMIT:  state_nxt = last_iter ? OUTPUT : SHIFT;
            OUTPUT:  state_nxt = DONE;
            DONE:
            begin
                if (ack)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Moore decode of the strobes
    assign load_en   = (state == LOAD);
    assign shift_en  = (state == SHIFT);
    assign wr_en     = (state == UPDATE);
    assign commit_en = (state == COMMIT);
    assign out_en    = (state == OUTPUT);

    // ========================================================================
    // State, counters and ready
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            ready   <= 1'b0;
            iter    <= '0;
            var_sel <= VAR_X;
        end
        else
        begin
            state <= state_nxt;
            ready <= (state_nxt == DONE);            // Rises with the registered result
            if (load_en)
                iter <= '0;
            else if (commit_en)
                iter <= iter + ITER_BITS'(1);        // Wraps to 0 after the last one
            if (wr_en)
                var_sel <= (var_sel == VAR_Z) ? VAR_X : var_sel_t'(var_sel + 2'd1);
        end
    end

    // Ready stays up until the host acks, then drops
    a_ready_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> (ready == !$past(ack)));

    // Variable counter wraps after Z and never grants the unused code
    a_var_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state == UPDATE) |-> (var_sel != var_sel_t'(VAR_Z + 1)));

endmodule

/* rtl/cordic_addsub_share.sv */
// Shared add/subtract unit with operand muxes and direction decision
module cordic_addsub_share (
    input  cordic_ctrl_pkg::var_sel_t var_sel,    // Granted variable
    input  cordic_num_pkg::data_t     x_snap,     // Start-of-iteration X
    input  cordic_num_pkg::data_t     y_snap,     // Start-of-iteration Y
    input  cordic_num_pkg::data_t     z_snap,     // Start-of-iteration Z
    input  cordic_num_pkg::data_t     x_shifted,  // X >>> i
    input  cordic_num_pkg::data_t     y_shifted,  // Y >>> i
    input  cordic_num_pkg::data_t     atan,       // atan(2^-i)
    output cordic_num_pkg::data_t     sum         // New value of the granted variable
);
    import cordic_num_pkg::*;
    import cordic_ctrl_pkg::*;

    data_t op_a;
    data_t op_b;
    logic  z_neg;       // d = -1
    logic  do_sub;

    assign z_neg = z_snap[DATA_W-1];

    // Operand selection, rotation mode with d from the sign of Z
    always_comb
    begin
        case (var_sel)
            VAR_X:
            begin
                op_a   = x_snap;
                op_b   = y_shifted;
                do_sub = !z_neg;                     // x - d*y*2^-i
            end
            VAR_Y:
            begin
                op_a   = y_snap;
                op_b   = x_shifted;
                do_sub = z_neg;                      // y + d*x*2^-i
            end
            default:
            begin
                op_a   = z_snap;
                op_b   = atan;
                do_sub = !z_neg;                     // z - d*atan
            end
        endcase
    end

    assign sum = do_sub ? (op_a - op_b) : (op_a + op_b);   // Wrap-around

    // The unused grant code would silently route to Z
    always_comb
    begin
        if (!$isunknown(var_sel))
        begin
            a_var_sel_legal: assert (var_sel inside {VAR_X, VAR_Y, VAR_Z});
        end
    end

endmodule

/* rtl/cordic_datapath.sv */
// X/Y/Z working registers, iteration snapshot, shift stage and write-back
module cordic_datapath #(
    parameter int ITER_BITS = cordic_num_pkg::ITER_BITS_DEF  // Iteration counter width
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_en,
    input  logic                      shift_en,
    input  logic                      wr_en,
    input  logic                      commit_en,
    input  cordic_ctrl_pkg::var_sel_t var_sel,
    input  logic [ITER_BITS-1:0]      iter,
    input  cordic_num_pkg::data_t     angle,      // Reduced angle, start value of Z
    input  cordic_num_pkg::data_t     sum,        // From the shared adder
    output cordic_num_pkg::data_t     x_snap,
    output cordic_num_pkg::data_t     y_snap,
    output cordic_num_pkg::data_t     z_snap,
    output cordic_num_pkg::data_t     x_shifted,
    output cordic_num_pkg::data_t     y_shifted
);
    import cordic_num_pkg::*;
    import cordic_ctrl_pkg::*;

    data_t x_reg;
    data_t y_reg;
    data_t z_reg;
    data_t x_next;
    data_t y_next;
    data_t z_next;

    // ========================================================================
    // Working registers
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            x_reg <= CORDIC_GAIN_INV;                // Pre-scaled by 1/K
            y_reg <= '0;
            z_reg <= angle;
        end
        else if (commit_en)
        begin
            x_reg <= x_next;
            y_reg <= y_next;
            z_reg <= z_next;
        end
    end

    // ========================================================================
    // Snapshot and shift stage
    // ========================================================================
    // Snapshot also follows the commit, so after the last iteration
    // the output stage sees the final X and Y without another shift
    always_ff @(posedge clk)
    begin
        if (shift_en)
        begin
            x_snap    <= x_reg;
            y_snap    <= y_reg;
            z_snap    <= z_reg;
            x_shifted <= x_reg >>> iter;             // Arithmetic, keeps the sign
            y_shifted <= y_reg >>> iter;
        end
        else if (commit_en)
        begin
            x_snap <= x_next;
            y_snap <= y_next;
        end
    end

    // Write-back of the granted variable
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (var_sel)
                VAR_X:   x_next <= sum;
                VAR_Y:   y_next <= sum;
                VAR_Z:   z_next <= sum;
                default: z_next <= z_next;           // Unused code
            endcase
        end
    end

    // Commit only right after the Z write of the same iteration
    a_commit_after_z: assert property (@(posedge clk) disable iff (!rst_n)
        commit_en |-> $past(wr_en && (var_sel == VAR_Z)));

endmodule

/* rtl/cordic_result_stage.sv */
// Quadrant correction, sine/cosine pick and result register
module cordic_result_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_en,   // Capture op_sin and quadrant
    input  logic                       out_en,    // Register the corrected value
    input  logic                       op_sin,    // 1 sine, 0 cosine
    input  cordic_ctrl_pkg::quadrant_t quadrant,
    input  cordic_num_pkg::data_t      x_snap,    // Final cosine of reduced angle
    input  cordic_num_pkg::data_t      y_snap,    // Final sine of reduced angle
    output cordic_num_pkg::data_t      result
);
    import cordic_num_pkg::*;
    import cordic_ctrl_pkg::*;

    logic      op_sin_q;
    quadrant_t quad_q;
    logic      pick_y;
    logic      negate;
    data_t     picked;

    // Odd quadrants swap sine and cosine
    assign pick_y = op_sin_q ^ quad_q[0];
    // Sine negative in k=2,3, cosine in k=1,2
    assign negate = op_sin_q ? quad_q[1] : (quad_q[1] ^ quad_q[0]);
    assign picked = pick_y ? y_snap : x_snap;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            op_sin_q <= 1'b0;
            quad_q   <= '0;
            result   <= '0;
        end
        else
        begin
            if (load_en)
            begin
                op_sin_q <= op_sin;
                quad_q   <= quadrant;
            end
            if (out_en)
                result <= negate ? -picked : picked;   // Held until next out_en
        end
    end

endmodule

/* rtl/cordic_sincos.sv */
// Top of the iterative CORDIC sine/cosine unit: instances and wiring
module cordic_sincos #(
    parameter int ITER_BITS = cordic_num_pkg::ITER_BITS_DEF  // 3 to 5 supported
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       ack,
    input  logic                       op_sin,
    input  cordic_ctrl_pkg::quadrant_t quadrant,
    input  cordic_num_pkg::data_t      angle,
    output logic                       ready,
    output cordic_num_pkg::data_t      result
);
    import cordic_num_pkg::*;
    import cordic_ctrl_pkg::*;

    // ========================================================================
    // Control strobes
    // ========================================================================
    logic                 load_en;
    logic                 shift_en;
    logic                 wr_en;
    logic                 commit_en;
    logic                 out_en;
    var_sel_t             var_sel;
    logic [ITER_BITS-1:0] iter;

    // Datapath buses
    data_t atan;
    data_t sum;
    data_t x_snap;
    data_t y_snap;
    data_t z_snap;
    data_t x_shifted;
    data_t y_shifted;

    cordic_fsm #(.ITER_BITS(ITER_BITS)) i_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .ack       (ack),
        .ready     (ready),
        .load_en   (load_en),
        .shift_en  (shift_en),
        .wr_en     (wr_en),
        .commit_en (commit_en),
        .out_en    (out_en),
        .var_sel   (var_sel),
        .iter      (iter)
    );

    cordic_atan_rom #(.ITER_BITS(ITER_BITS)) i_atan_rom (
        .iter (iter),
        .atan (atan)
    );

    cordic_datapath #(.ITER_BITS(ITER_BITS)) i_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .shift_en  (shift_en),
        .wr_en     (wr_en),
        .commit_en (commit_en),
        .var_sel   (var_sel),
        .iter      (iter),
        .angle     (angle),
        .sum       (sum),
        .x_snap    (x_snap),
        .y_snap    (y_snap),
        .z_snap    (z_snap),
        .x_shifted (x_shifted),
        .y_shifted (y_shifted)
    );

    // One adder, time-shared X, Y, Z by the variable counter
    cordic_addsub_share i_addsub (
        .var_sel   (var_sel),
        .x_snap    (x_snap),
        .y_snap    (y_snap),
        .z_snap    (z_snap),
        .x_shifted (x_shifted),
        .y_shifted (y_shifted),
        .atan      (atan),
        .sum       (sum)
    );

    cordic_result_stage i_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (load_en),
        .out_en   (out_en),
        .op_sin   (op_sin),
        .quadrant (quadrant),
        .x_snap   (x_snap),
        .y_snap   (y_snap),
        .result   (result)
    );

endmodule

/* test/tb_cordic_tasks.svh */
// Testbench tasks: failure stop, value check, one handshake transaction and directed tests

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
        fail_stop($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
endtask

// One start/ready/ack exchange, optional input noise while busy and ack delay
task automatic run_op(input data_t ang, input logic sin_sel, input quadrant_t k,
                      input bit busy_noise, input int hold, output data_t res);
    int    cycles;
    data_t held;
    @(negedge clk);
    angle    = ang;
    op_sin   = sin_sel;
    quadrant = k;
    start    = 1'b1;
    @(posedge clk);                                // Accepting edge, unit is idle
    cycles = 0;
    @(negedge clk);
    start = 1'b0;                                  // Inputs held through LOAD
    while (!ready && cycles < LATENCY + 20)
    begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
        if (busy_noise && !ready)
        begin
            start    = 1'($urandom_range(1));      // Must be ignored while busy
            angle    = data_t'($urandom);
            op_sin   = 1'($urandom_range(1));
            quadrant = quadrant_t'($urandom_range(3));
        end
    end
    if (!ready)
        fail_stop("ready did not rise within the expected time after start");
    start = 1'b0;
    check_value("latency", 32'(cycles), 32'(LATENCY));
    res  = result;
    held = result;
    repeat (hold)
    begin
        @(negedge clk);
        check_value("ready", 32'(ready), 32'd1);   // Held while ack is low
        check_value("result", result, held);
    end
    ack = 1'b1;
    @(negedge clk);
    ack = 1'b0;
    check_value("ready", 32'(ready), 32'd0);       // Dropped on ack
endtask

// ============================================================================
// Directed tests
// ============================================================================
task automatic test_reset();
    for (int i = 0; i < 3; i++)
    begin
        start = (i != 1);                          // Pulses under reset
        @(posedge clk);
        @(negedge clk);
    end
    rst_n = 1'b1;
    start = 1'b0;
    repeat (4)
    begin
        check_value("ready", 32'(ready), 32'd0);
        check_value("result", result, 32'd0);
        @(negedge clk);
    end
endtask

task automatic test_zero_angle();
    data_t res;
    logic  near;
    run_op('0, 1'b0, 2'd0, 1'b0, 0, res);
    check_value("result", res, model_sincos('0, 1'b0, 2'd0));
    near = (res > 32'sh3FFC0000) && (res < 32'sh40040000);       // Cosine near one
    check_value("cos_near_one", 32'(near), 32'd1);
    run_op('0, 1'b1, 2'd0, 1'b0, 0, res);
    check_value("result", res, model_sincos('0, 1'b1, 2'd0));
    near = (res > -32'sh00040000) && (res < 32'sh00040000);      // Sine near zero
    check_value("sin_near_zero", 32'(near), 32'd1);
endtask

task automatic test_latency();
    data_t res;
    run_op(32'sh1921FB54, 1'b1, 2'd0, 1'b0, 0, res);             // pi/8
    check_value("result", res, model_sincos(32'sh1921FB54, 1'b1, 2'd0));
    run_op(32'sh1921FB54, 1'b1, 2'd0, 1'b1, 0, res);             // Start noise while busy
    check_value("result", res, model_sincos(32'sh1921FB54, 1'b1, 2'd0));
endtask

task automatic test_quadrants();
    data_t res;
    for (int k = 0; k < 4; k++)
    begin
        for (int f = 0; f < 2; f++)
        begin
            run_op(32'sh20000000, 1'(f), quadrant_t'(k), 1'b0, 0, res);   // 0.5 rad
            check_value("result", res, model_sincos(32'sh20000000, 1'(f), quadrant_t'(k)));
        end
    end
endtask

task automatic test_random_sweep();
    data_t     ang;
    logic      f;
    quadrant_t k;
    data_t     res;
    repeat (20)
    begin
        ang = data_t'($urandom_range(32'hC0000000, 0)) - 32'sh60000000;   // [-1.5, 1.5]
        f   = 1'($urandom_range(1));
        k   = quadrant_t'($urandom_range(3));
        run_op(ang, f, k, 1'b0, 0, res);
        check_value("result", res, model_sincos(ang, f, k));
    end
endtask

task automatic test_back_pressure();
    data_t res;
    int    hold;
    hold = int'($urandom_range(20, 1));
    run_op(-32'sh2AAAAAAB, 1'b1, 2'd3, 1'b0, hold, res);          // -2/3 rad, ack late
    check_value("result", res, model_sincos(-32'sh2AAAAAAB, 1'b1, 2'd3));
    run_op(32'sh0CCCCCCD, 1'b0, 2'd1, 1'b0, 0, res);              // Next start after ack
    check_value("result", res, model_sincos(32'sh0CCCCCCD, 1'b0, 2'd1));
endtask

/* test/tb_cordic_sincos.sv */
// Testbench top: clock, reset, watchdog, CORDIC reference model and test sequence
module tb_cordic_sincos;
    import cordic_num_pkg::*;
    import cordic_ctrl_pkg::*;

    localparam int ITER_BITS = 4;
    localparam int N_ITER    = 1 << ITER_BITS;     // 16 iterations
    localparam int LATENCY   = 2 + 5 * N_ITER;     // Accepting edge to ready
    localparam int NUM_TRANS = 34;                 // Transactions over the whole run

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        ack;
    logic        op_sin;
    quadrant_t   quadrant;
    data_t       angle;
    logic        ready;
    data_t       result;
    data_t       atan_ref [N_ITER];                // Model table, from real math
    int unsigned seed_init;

    cordic_sincos #(.ITER_BITS(ITER_BITS)) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .ack      (ack),
        .op_sin   (op_sin),
        .quadrant (quadrant),
        .angle    (angle),
        .ready    (ready),
        .result   (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // Period 100
    end

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic void build_atan_table();
        real step;
        step = 1.0;
        for (int i = 0; i < N_ITER; i++)
        begin
            atan_ref[i] = data_t'($rtoi($atan(step) * 1073741824.0 + 0.5));   // Rounded Q2.30
            step = step / 2.0;
        end
    endfunction

    function automatic data_t model_sincos(input data_t ang, input logic sin_sel,
                                           input quadrant_t k);
        data_t x;
        data_t y;
        data_t z;
        data_t x_sh;
        data_t y_sh;
        data_t val;
        x = 32'h26DD3B6A;                          // 1/K
        y = '0;
        z = ang;
        for (int i = 0; i < N_ITER; i++)
        begin
            x_sh = x >>> i;                        // Both from the old values
            y_sh = y >>> i;
            if (!z[31])
            begin
                x = x - y_sh;                      // d = +1
                y = y + x_sh;
                z = z - atan_ref[i];
            end
            else
            begin
                x = x + y_sh;                      // d = -1
                y = y - x_sh;
                z = z + atan_ref[i];
            end
        end
        case ({sin_sel, k})
            3'b100:  val = y;                      // Sine: sin, cos, -sin, -cos
            3'b101:  val = x;
            3'b110:  val = -y;
            3'b111:  val = -x;
            3'b000:  val = x;                      // Cosine: cos, -sin, -cos, sin
            3'b001:  val = -y;
            3'b010:  val = -x;
            default: val = y;
        endcase
        return val;
    endfunction

    `include "tb_cordic_tasks.svh"

    // Watchdog sized from the transaction count
    initial
    begin
        repeat (NUM_TRANS * 90 + 100) @(posedge clk);
        fail_stop("Watchdog expired, the run timed out before all tests finished");
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial
    begin
        rst_n     = 1'b0;
        start     = 1'b0;
        ack       = 1'b0;
        op_sin    = 1'b0;
        quadrant  = '0;
        angle     = '0;
        seed_init = $urandom(62797);
        build_atan_table();
        test_reset();
        test_zero_angle();
        test_latency();
        test_quadrants();
        test_random_sweep();
        test_back_pressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+test
rtl/cordic_num_pkg.sv
rtl/cordic_ctrl_pkg.sv
rtl/cordic_atan_rom.sv
rtl/cordic_fsm.sv
rtl/cordic_addsub_share.sv
rtl/cordic_datapath.sv
rtl/cordic_result_stage.sv
rtl/cordic_sincos.sv
test/tb_cordic_sincos.sv

/* run.sh */
#!/bin/sh
# Build and run the CORDIC testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_cordic_sincos
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module "$TOP" -o "$TOP" > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
